// ==== verilog/isaPkg.sv ====
package isaPkg;

    // Instruction field widths
    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int REG_W    = 5;   // rs, rt, rd and shamt

    // Low bit of each field in the instruction word
    localparam int SHAMT_LSB = 6;
    localparam int RT_LSB    = 16;
    localparam int RS_LSB    = 21;

    // Primary opcode, bits 31:26
    typedef enum logic [OPCODE_W-1:0] {
        opSpecial  = 6'h00,
        opRegimm   = 6'h01,
        opJ        = 6'h02,
        opJal      = 6'h03,
        opBeq      = 6'h04,
        opBne      = 6'h05,
        opBlez     = 6'h06,
        opBgtz     = 6'h07,
        opAddi     = 6'h08,
        opAddiu    = 6'h09,
        opSlti     = 6'h0A,
        opSltiu    = 6'h0B,
        opAndi     = 6'h0C,
        opOri      = 6'h0D,
        opXori     = 6'h0E,
        opLui      = 6'h0F,
        opSpecial2 = 6'h1C,
        opSpecial3 = 6'h1F,
        opLb       = 6'h20,
        opLh       = 6'h21,
        opLw       = 6'h23,
        opSb       = 6'h28,
        opSh       = 6'h29,
        opSw       = 6'h2B
    } opcode_e;

    // SPECIAL funct, bits 5:0
    typedef enum logic [FUNCT_W-1:0] {
        fnSll   = 6'h00,
        fnSrl   = 6'h02,   // rotr when bit 21 set
        fnSra   = 6'h03,
        fnSllv  = 6'h04,
        fnSrlv  = 6'h06,   // rotrv when shamt is 1
        fnSrav  = 6'h07,
        fnJr    = 6'h08,
        fnMovz  = 6'h0A,
        fnMovn  = 6'h0B,
        fnMfhi  = 6'h10,
        fnMthi  = 6'h11,
        fnMflo  = 6'h12,
        fnMtlo  = 6'h13,
        fnMult  = 6'h18,
        fnMultu = 6'h19,
        fnAdd   = 6'h20,
        fnAddu  = 6'h21,
        fnSub   = 6'h22,
        fnAnd   = 6'h24,
        fnOr    = 6'h25,
        fnXor   = 6'h26,
        fnNor   = 6'h27,
        fnSlt   = 6'h2A,
        fnSltu  = 6'h2B
    } funct_e;

    // SPECIAL2 funct
    typedef enum logic [FUNCT_W-1:0] {
        fn2Madd = 6'h00,
        fn2Mul  = 6'h02,
        fn2Msub = 6'h04
    } funct2_e;

    // REGIMM rt field
    typedef enum logic [REG_W-1:0] {
        rtBltz = 5'd0,
        rtBgez = 5'd1
    } regimmRt_e;

    // SPECIAL3 sa field
    typedef enum logic [REG_W-1:0] {
        saSeb = 5'd16,
        saSeh = 5'd24
    } special3Sa_e;

endpackage

// ==== verilog/ctrlPkg.sv ====
package ctrlPkg;

    // Must match the ALU operation codes
    typedef enum logic [4:0] {
        aluAdd  = 5'd0,  aluSub  = 5'd1,  aluMult = 5'd2,  aluAnd  = 5'd3,
        aluOr   = 5'd4,  aluNor  = 5'd5,  aluXor  = 5'd6,  aluSll  = 5'd7,
        aluSrl  = 5'd8,  aluRotr = 5'd9,  aluSlt  = 5'd10, aluMovn = 5'd11,
        aluMovz = 5'd12, aluSra  = 5'd13, aluSltu = 5'd14, aluMthi = 5'd15,
        aluMtlo = 5'd16, aluMfhi = 5'd17, aluMflo = 5'd18, aluMul  = 5'd19,
        aluMadd = 5'd20, aluMsub = 5'd21, aluSeh  = 5'd22, aluSeb  = 5'd23,
        aluBgez = 5'd24, aluBltz = 5'd25, aluBgtz = 5'd26, aluBlez = 5'd27,
        aluLui  = 5'd28, aluNone = 5'd31
    } aluOp_e;

    typedef enum logic [1:0] {dstRt = 2'd0, dstRd = 2'd1, dstRa = 2'd2} regDst_e;

    typedef enum logic [1:0] {hlNoWrite = 2'd0, hlHi = 2'd1, hlLo = 2'd2, hlBoth = 2'd3} hiLo_e;

    typedef enum logic [1:0] {dtWord = 2'd0, dtHalf = 2'd1, dtByte = 2'd2} dataType_e;

    // Which function table the decoder consults
    typedef enum logic [2:0] {
        spNone, spSpecial, spSpecial2, spRegimm, spSpecial3
    } funcSpace_e;

    typedef struct packed {
        regDst_e   regDst;
        logic      aluSrc;      // 1 selects the immediate
        logic      aluSrc2;     // 1 selects shamt as shift amount
        logic      memToReg;
        logic      regWrite;
        hiLo_e     hiLoWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        dataType_e dataType;
        aluOp_e    aluOp;
        logic      signExtend;
    } ctrl_t;

    // Bubble value, all controls off
    localparam ctrl_t CTRL_IDLE = '{
        regDst: dstRt, aluSrc: 1'b0, aluSrc2: 1'b0, memToReg: 1'b0, regWrite: 1'b0,
        hiLoWrite: hlNoWrite, memRead: 1'b0, memWrite: 1'b0, branch: 1'b0, jump: 1'b0,
        dataType: dtWord, aluOp: aluNone, signExtend: 1'b0
    };

endpackage

// ==== verilog/funcDecIf.sv ====
// Opcode decoder and function table decoder exchange
interface funcDecIf;

    ctrlPkg::funcSpace_e space;      // Table selected by the opcode
    ctrlPkg::aluOp_e     aluOp;
    logic                aluSrc2;
    ctrlPkg::hiLo_e      hiLoWrite;
    logic                jumpReg;    // jr seen
    logic                known;      // Entry found in the selected table

    modport mainSide (
        output space,
        input  aluOp, aluSrc2, hiLoWrite, jumpReg, known
    );

    modport funcSide (
        input  space,
        output aluOp, aluSrc2, hiLoWrite, jumpReg, known
    );

endinterface

// ==== verilog/funcDecoder.sv ====
module funcDecoder #(
    parameter int FUNCT_W = 6,
    parameter int REG_W   = 5
) (
    input  logic [FUNCT_W-1:0] funct,
    input  logic [REG_W-1:0]   shamt,
    input  logic [REG_W-1:0]   rt,
    input  logic               rsLow,     // Instruction bit 21
    funcDecIf.funcSide         fd
);

    ctrlPkg::aluOp_e aluOp;
    logic            aluSrc2;
    ctrlPkg::hiLo_e  hiLoWrite;
    logic            jumpReg;
    logic            known;

    always_comb begin
        aluOp     = ctrlPkg::aluNone;
        aluSrc2   = 1'b0;
        hiLoWrite = ctrlPkg::hlNoWrite;
        jumpReg   = 1'b0;
        known     = 1'b1;   // Cleared by every miss below

        case (fd.space)
            ctrlPkg::spSpecial: begin
                case (funct)
                    isaPkg::fnAdd, isaPkg::fnAddu: aluOp = ctrlPkg::aluAdd;
                    isaPkg::fnSub:                 aluOp = ctrlPkg::aluSub;
                    isaPkg::fnMult, isaPkg::fnMultu: begin
                        aluOp     = ctrlPkg::aluMult;
                        hiLoWrite = ctrlPkg::hlBoth;
                    end
                    isaPkg::fnAnd:  aluOp = ctrlPkg::aluAnd;
                    isaPkg::fnOr:   aluOp = ctrlPkg::aluOr;
                    isaPkg::fnNor:  aluOp = ctrlPkg::aluNor;
                    isaPkg::fnXor:  aluOp = ctrlPkg::aluXor;
                    isaPkg::fnSlt:  aluOp = ctrlPkg::aluSlt;
                    isaPkg::fnSltu: aluOp = ctrlPkg::aluSltu;
                    isaPkg::fnSll: begin
                        aluOp   = ctrlPkg::aluSll;
                        aluSrc2 = 1'b1;
                    end
                    isaPkg::fnSllv: aluOp = ctrlPkg::aluSll;   // Amount from rs
                    isaPkg::fnSrl: begin
                        aluOp   = rsLow ? ctrlPkg::aluRotr : ctrlPkg::aluSrl;
                        aluSrc2 = 1'b1;
                    end
                    isaPkg::fnSrlv: begin
                        // shamt field picks srlv or rotrv
                        if (shamt == REG_W'(0))
                            aluOp = ctrlPkg::aluSrl;
                        else if (shamt == REG_W'(1))
                            aluOp = ctrlPkg::aluRotr;
                        else
                            known = 1'b0;
                    end
                    isaPkg::fnSra: begin
                        aluOp   = ctrlPkg::aluSra;
                        aluSrc2 = 1'b1;
                    end
                    isaPkg::fnSrav: aluOp = ctrlPkg::aluSra;
                    isaPkg::fnMovn: aluOp = ctrlPkg::aluMovn;
                    isaPkg::fnMovz: aluOp = ctrlPkg::aluMovz;
                    isaPkg::fnMthi: begin
                        aluOp     = ctrlPkg::aluMthi;
                        hiLoWrite = ctrlPkg::hlHi;
                    end
                    isaPkg::fnMtlo: begin
                        aluOp     = ctrlPkg::aluMtlo;
                        hiLoWrite = ctrlPkg::hlLo;
                    end
                    isaPkg::fnMfhi: aluOp = ctrlPkg::aluMfhi;
                    isaPkg::fnMflo: aluOp = ctrlPkg::aluMflo;
                    isaPkg::fnJr:   jumpReg = 1'b1;   // ALU unused
                    default:        known = 1'b0;
                endcase
            end
            ctrlPkg::spSpecial2: begin
                case (funct)
                    isaPkg::fn2Mul: aluOp = ctrlPkg::aluMul;
                    isaPkg::fn2Madd: begin
                        aluOp     = ctrlPkg::aluMadd;
                        hiLoWrite = ctrlPkg::hlBoth;
                    end
                    isaPkg::fn2Msub: begin
                        aluOp     = ctrlPkg::aluMsub;
                        hiLoWrite = ctrlPkg::hlBoth;
                    end
                    default: known = 1'b0;
                endcase
            end
            ctrlPkg::spRegimm: begin
                case (rt)
                    isaPkg::rtBgez: aluOp = ctrlPkg::aluBgez;
                    isaPkg::rtBltz: aluOp = ctrlPkg::aluBltz;
                    default:        known = 1'b0;
                endcase
            end
            ctrlPkg::spSpecial3: begin
                case (shamt)
                    isaPkg::saSeh: aluOp = ctrlPkg::aluSeh;
                    isaPkg::saSeb: aluOp = ctrlPkg::aluSeb;
                    default:       known = 1'b0;
                endcase
            end
            default: known = 1'b0;   // No table for this opcode
        endcase
    end

    assign fd.aluOp     = aluOp;
    assign fd.aluSrc2   = aluSrc2;
    assign fd.hiLoWrite = hiLoWrite;
    assign fd.jumpReg   = jumpReg;
    assign fd.known     = known;

endmodule

// ==== verilog/mainDecoder.sv ====
module mainDecoder (
    input  isaPkg::opcode_e opcode,
    funcDecIf.mainSide      fd,
    output ctrlPkg::ctrl_t  ctrl
);

    // Access size shared by loads and stores
    function automatic ctrlPkg::dataType_e memType(isaPkg::opcode_e op);
        case (op)
            isaPkg::opLh, isaPkg::opSh: memType = ctrlPkg::dtHalf;
            isaPkg::opLb, isaPkg::opSb: memType = ctrlPkg::dtByte;
            default:                    memType = ctrlPkg::dtWord;
        endcase
    endfunction

    // Function table selection
    always_comb begin
        case (opcode)
            isaPkg::opSpecial:  fd.space = ctrlPkg::spSpecial;
            isaPkg::opSpecial2: fd.space = ctrlPkg::spSpecial2;
            isaPkg::opSpecial3: fd.space = ctrlPkg::spSpecial3;
            isaPkg::opRegimm:   fd.space = ctrlPkg::spRegimm;
            default:            fd.space = ctrlPkg::spNone;
        endcase
    end

    always_comb begin
        ctrl = ctrlPkg::CTRL_IDLE;

        case (opcode)
            isaPkg::opSpecial, isaPkg::opSpecial2, isaPkg::opSpecial3: begin
                // Unlisted sub-field stays a bubble
                if (fd.known) begin
                    ctrl.regDst    = ctrlPkg::dstRd;
                    ctrl.aluOp     = fd.aluOp;
                    ctrl.aluSrc2   = fd.aluSrc2;
                    ctrl.hiLoWrite = fd.hiLoWrite;
                    ctrl.regWrite  = !fd.jumpReg;   // jr writes nothing
                    ctrl.jump      = fd.jumpReg;
                end
            end

            isaPkg::opRegimm: begin
                if (fd.known) begin
                    ctrl.branch     = 1'b1;
                    ctrl.signExtend = 1'b1;
                    ctrl.aluOp      = fd.aluOp;
                end
            end

            isaPkg::opLw, isaPkg::opLh, isaPkg::opLb: begin
                ctrl.regDst     = ctrlPkg::dstRt;
                ctrl.aluSrc     = 1'b1;
                ctrl.memToReg   = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.memRead    = 1'b1;
                ctrl.aluOp      = ctrlPkg::aluAdd;   // Base plus offset
                ctrl.signExtend = 1'b1;
                ctrl.dataType   = memType(opcode);
            end

            isaPkg::opSw, isaPkg::opSh, isaPkg::opSb: begin
                ctrl.aluSrc     = 1'b1;
                ctrl.memWrite   = 1'b1;
                ctrl.aluOp      = ctrlPkg::aluAdd;
                ctrl.signExtend = 1'b1;
                ctrl.dataType   = memType(opcode);
            end

            isaPkg::opBeq, isaPkg::opBne: begin
                ctrl.branch     = 1'b1;
                ctrl.aluOp      = ctrlPkg::aluSub;   // Compare by subtraction
                ctrl.signExtend = 1'b1;
            end

            isaPkg::opBgtz, isaPkg::opBlez: begin
                ctrl.branch     = 1'b1;
                ctrl.signExtend = 1'b1;
                ctrl.aluOp      = (opcode == isaPkg::opBgtz) ? ctrlPkg::aluBgtz
                                                             : ctrlPkg::aluBlez;
            end

            isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu,
            isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opLui: begin
                ctrl.regDst   = ctrlPkg::dstRt;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;

                // Arithmetic immediates are signed, logical ones zero-extended
                case (opcode)
                    isaPkg::opAddi, isaPkg::opAddiu: begin
                        ctrl.aluOp      = ctrlPkg::aluAdd;
                        ctrl.signExtend = 1'b1;
                    end
                    isaPkg::opSlti: begin
                        ctrl.aluOp      = ctrlPkg::aluSlt;
                        ctrl.signExtend = 1'b1;
                    end
                    isaPkg::opSltiu: begin
                        ctrl.aluOp      = ctrlPkg::aluSltu;
                        ctrl.signExtend = 1'b1;
                    end
                    isaPkg::opAndi: ctrl.aluOp = ctrlPkg::aluAnd;
                    isaPkg::opOri:  ctrl.aluOp = ctrlPkg::aluOr;
                    isaPkg::opXori: ctrl.aluOp = ctrlPkg::aluXor;
                    isaPkg::opLui:  ctrl.aluOp = ctrlPkg::aluLui;
                    default:        ctrl.aluOp = ctrlPkg::aluNone;
                endcase
            end

            isaPkg::opJ: ctrl.jump = 1'b1;

            isaPkg::opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.regDst   = ctrlPkg::dstRa;   // Link into r31
                ctrl.regWrite = 1'b1;
            end

            default: ctrl = ctrlPkg::CTRL_IDLE;
        endcase
    end

endmodule

// ==== verilog/controlUnit.sv ====
module controlUnit #(
    parameter int INSTR_W = 32,
    parameter int FUNCT_W = 6,
    parameter int REG_W   = 5
) (
    input  logic               Clk,
    input  logic               rst,
    input  logic [INSTR_W-1:0] instr,
    input  logic               instrValid,
    output ctrlPkg::regDst_e   regDst,
    output logic               aluSrc,
    output logic               aluSrc2,
    output logic               memToReg,
    output logic               regWrite,
    output ctrlPkg::hiLo_e     hiLoWrite,
    output logic               memRead,
    output logic               memWrite,
    output logic               branch,
    output logic               jump,
    output ctrlPkg::dataType_e dataType,
    output ctrlPkg::aluOp_e    aluOp,
    output logic               signExtend,
    output logic               ctrlValid
);

    isaPkg::opcode_e opcode;
    ctrlPkg::ctrl_t  decCtrl;   // Combinational decode
    ctrlPkg::ctrl_t  ctrlQ;     // Decode/execute register

    funcDecIf fdIf ();

    assign opcode = isaPkg::opcode_e'(instr[INSTR_W-1 -: isaPkg::OPCODE_W]);

    funcDecoder #(
        .FUNCT_W (FUNCT_W),
        .REG_W   (REG_W)
    ) uFuncDec (
        .funct (instr[FUNCT_W-1:0]),
        .shamt (instr[isaPkg::SHAMT_LSB +: REG_W]),
        .rt    (instr[isaPkg::RT_LSB +: REG_W]),
        .rsLow (instr[isaPkg::RS_LSB]),
        .fd    (fdIf)
    );

    mainDecoder uMainDec (
        .opcode (opcode),
        .fd     (fdIf),
        .ctrl   (decCtrl)
    );

    // Invalid slots load a bubble
    always_ff @(posedge Clk) begin
        if (rst) begin
            ctrlQ     <= ctrlPkg::CTRL_IDLE;
            ctrlValid <= 1'b0;
        end else begin
            ctrlQ     <= instrValid ? decCtrl : ctrlPkg::CTRL_IDLE;
            ctrlValid <= instrValid;
        end
    end

    assign regDst     = ctrlQ.regDst;
    assign aluSrc     = ctrlQ.aluSrc;
    assign aluSrc2    = ctrlQ.aluSrc2;
    assign memToReg   = ctrlQ.memToReg;
    assign regWrite   = ctrlQ.regWrite;
    assign hiLoWrite  = ctrlQ.hiLoWrite;
    assign memRead    = ctrlQ.memRead;
    assign memWrite   = ctrlQ.memWrite;
    assign branch     = ctrlQ.branch;
    assign jump       = ctrlQ.jump;
    assign dataType   = ctrlQ.dataType;
    assign aluOp      = ctrlQ.aluOp;
    assign signExtend = ctrlQ.signExtend;

    memExclusive: assert property (@(posedge Clk) disable iff (rst) !(memRead && memWrite))
        else $error("memRead and memWrite both set");

    flowExclusive: assert property (@(posedge Clk) disable iff (rst) !(branch && jump))
        else $error("branch and jump both set");

    loadPath: assert property (@(posedge Clk) disable iff (rst) memToReg |-> memRead)
        else $error("memToReg without memRead");

    // Bubble must carry no side effects
    idleBubble: assert property (@(posedge Clk) disable iff (rst)
        !ctrlValid |-> (ctrlQ == ctrlPkg::CTRL_IDLE))
        else $error("Controls active while ctrlValid is low");

endmodule

// ==== bench/decodeRef.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Bubble with every control off
function automatic ctrlPkg::ctrl_t idleCtrl();
    ctrlPkg::ctrl_t c;
    c       = '0;
    c.aluOp = ctrlPkg::aluNone;
    return c;
endfunction

// Register-format result written to rd
function automatic ctrlPkg::ctrl_t regCtrl(ctrlPkg::aluOp_e op, logic src2,
                                           ctrlPkg::hiLo_e hl = ctrlPkg::hlNoWrite);
    ctrlPkg::ctrl_t c;
    c           = idleCtrl();
    c.regDst    = ctrlPkg::dstRd;
    c.regWrite  = 1'b1;
    c.aluOp     = op;
    c.aluSrc2   = src2;   // Shift amount from shamt
    c.hiLoWrite = hl;
    return c;
endfunction

function automatic ctrlPkg::ctrl_t immCtrl(ctrlPkg::aluOp_e op, logic sext);
    ctrlPkg::ctrl_t c;
    c            = idleCtrl();
    c.aluSrc     = 1'b1;
    c.regWrite   = 1'b1;
    c.aluOp      = op;
    c.signExtend = sext;
    return c;
endfunction

// Loads and stores share the address add
function automatic ctrlPkg::ctrl_t memCtrl(logic isLoad, ctrlPkg::dataType_e dt);
    ctrlPkg::ctrl_t c;
    c            = idleCtrl();
    c.aluSrc     = 1'b1;
    c.aluOp      = ctrlPkg::aluAdd;
    c.signExtend = 1'b1;
    c.dataType   = dt;
    c.memToReg   = isLoad;
    c.regWrite   = isLoad;
    c.memRead    = isLoad;
    c.memWrite   = !isLoad;
    return c;
endfunction

function automatic ctrlPkg::ctrl_t branchCtrl(ctrlPkg::aluOp_e op);
    ctrlPkg::ctrl_t c;
    c            = idleCtrl();
    c.branch     = 1'b1;
    c.signExtend = 1'b1;
    c.aluOp      = op;
    return c;
endfunction

// Expected controls for one instruction word
function automatic ctrlPkg::ctrl_t decodeRef(logic [31:0] w);
    logic [5:0]     op;
    logic [5:0]     fn;
    logic [4:0]     rt;
    logic [4:0]     sa;
    ctrlPkg::ctrl_t c;
    op = w[31:26];
    fn = w[5:0];
    rt = w[20:16];
    sa = w[10:6];
    c  = idleCtrl();   // Anything unlisted stays a bubble
    case (op)
        6'h00: begin
            case (fn)
                6'h00: c = regCtrl(ctrlPkg::aluSll, 1'b1);
                6'h02: begin
                    if (w[21])
                        c = regCtrl(ctrlPkg::aluRotr, 1'b1);
                    else
                        c = regCtrl(ctrlPkg::aluSrl, 1'b1);
                end
                6'h03: c = regCtrl(ctrlPkg::aluSra, 1'b1);
                6'h04: c = regCtrl(ctrlPkg::aluSll, 1'b0);
                6'h06: begin
                    if (sa == 5'd0)
                        c = regCtrl(ctrlPkg::aluSrl, 1'b0);
                    else if (sa == 5'd1)
                        c = regCtrl(ctrlPkg::aluRotr, 1'b0);   // rotrv
                end
                6'h07: c = regCtrl(ctrlPkg::aluSra, 1'b0);
                6'h08: begin
                    c          = regCtrl(ctrlPkg::aluNone, 1'b0);
                    c.regWrite = 1'b0;   // jr only redirects
                    c.jump     = 1'b1;
                end
                6'h0A: c = regCtrl(ctrlPkg::aluMovz, 1'b0);
                6'h0B: c = regCtrl(ctrlPkg::aluMovn, 1'b0);
                6'h10: c = regCtrl(ctrlPkg::aluMfhi, 1'b0);
                6'h11: c = regCtrl(ctrlPkg::aluMthi, 1'b0, ctrlPkg::hlHi);
                6'h12: c = regCtrl(ctrlPkg::aluMflo, 1'b0);
                6'h13: c = regCtrl(ctrlPkg::aluMtlo, 1'b0, ctrlPkg::hlLo);
                6'h18: c = regCtrl(ctrlPkg::aluMult, 1'b0, ctrlPkg::hlBoth);
                6'h19: c = regCtrl(ctrlPkg::aluMult, 1'b0, ctrlPkg::hlBoth);
                6'h20: c = regCtrl(ctrlPkg::aluAdd, 1'b0);
                6'h21: c = regCtrl(ctrlPkg::aluAdd, 1'b0);
                6'h22: c = regCtrl(ctrlPkg::aluSub, 1'b0);
                6'h24: c = regCtrl(ctrlPkg::aluAnd, 1'b0);
                6'h25: c = regCtrl(ctrlPkg::aluOr, 1'b0);
                6'h26: c = regCtrl(ctrlPkg::aluXor, 1'b0);
                6'h27: c = regCtrl(ctrlPkg::aluNor, 1'b0);
                6'h2A: c = regCtrl(ctrlPkg::aluSlt, 1'b0);
                6'h2B: c = regCtrl(ctrlPkg::aluSltu, 1'b0);
                default: c = idleCtrl();
            endcase
        end
        6'h1C: begin
            case (fn)
                6'h00: c = regCtrl(ctrlPkg::aluMadd, 1'b0, ctrlPkg::hlBoth);
                6'h02: c = regCtrl(ctrlPkg::aluMul, 1'b0);
                6'h04: c = regCtrl(ctrlPkg::aluMsub, 1'b0, ctrlPkg::hlBoth);
                default: c = idleCtrl();
            endcase
        end
        6'h1F: begin
            if (sa == 5'd24)
                c = regCtrl(ctrlPkg::aluSeh, 1'b0);
            else if (sa == 5'd16)
                c = regCtrl(ctrlPkg::aluSeb, 1'b0);
        end
        6'h01: begin
            if (rt == 5'd1)
                c = branchCtrl(ctrlPkg::aluBgez);
            else if (rt == 5'd0)
                c = branchCtrl(ctrlPkg::aluBltz);
        end
        6'h20: c = memCtrl(1'b1, ctrlPkg::dtByte);
        6'h21: c = memCtrl(1'b1, ctrlPkg::dtHalf);
        6'h23: c = memCtrl(1'b1, ctrlPkg::dtWord);
        6'h28: c = memCtrl(1'b0, ctrlPkg::dtByte);
        6'h29: c = memCtrl(1'b0, ctrlPkg::dtHalf);
        6'h2B: c = memCtrl(1'b0, ctrlPkg::dtWord);
        6'h04: c = branchCtrl(ctrlPkg::aluSub);   // beq
        6'h05: c = branchCtrl(ctrlPkg::aluSub);   // bne
        6'h06: c = branchCtrl(ctrlPkg::aluBlez);
        6'h07: c = branchCtrl(ctrlPkg::aluBgtz);
        6'h08: c = immCtrl(ctrlPkg::aluAdd, 1'b1);
        6'h09: c = immCtrl(ctrlPkg::aluAdd, 1'b1);
        6'h0A: c = immCtrl(ctrlPkg::aluSlt, 1'b1);
        6'h0B: c = immCtrl(ctrlPkg::aluSltu, 1'b1);
        6'h0C: c = immCtrl(ctrlPkg::aluAnd, 1'b0);
        6'h0D: c = immCtrl(ctrlPkg::aluOr, 1'b0);
        6'h0E: c = immCtrl(ctrlPkg::aluXor, 1'b0);
        6'h0F: c = immCtrl(ctrlPkg::aluLui, 1'b0);
        6'h02: c.jump = 1'b1;
        6'h03: begin
            c.jump     = 1'b1;
            c.regDst   = ctrlPkg::dstRa;   // Link register
            c.regWrite = 1'b1;
        end
        default: c = idleCtrl();
    endcase
    return c;
endfunction

`endif

// ==== bench/controlUnitTb.sv ====
module controlUnitTb;

    localparam int INSTR_W    = 32;
    // About 2450 cycles of stimulus plus margin
    localparam int MAX_CYCLES = 3000;

    logic               Clk;
    logic               rst;
    logic [INSTR_W-1:0] instr;
    logic               instrValid;
    ctrlPkg::regDst_e   regDst;
    logic               aluSrc;
    logic               aluSrc2;
    logic               memToReg;
    logic               regWrite;
    ctrlPkg::hiLo_e     hiLoWrite;
    logic               memRead;
    logic               memWrite;
    logic               branch;
    logic               jump;
    ctrlPkg::dataType_e dataType;
    ctrlPkg::aluOp_e    aluOp;
    logic               signExtend;
    logic               ctrlValid;

    int         mismatchCount = 0;
    int         otherCount    = 0;
    int         cycleCount    = 0;
    logic [5:0] knownOps [0:23];   // Opcodes the decoder lists

    `include "decodeRef.svh"

    controlUnit #(
        .INSTR_W (INSTR_W),
        .FUNCT_W (6),
        .REG_W   (5)
    ) u_dut (
        .Clk        (Clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .regDst     (regDst),
        .aluSrc     (aluSrc),
        .aluSrc2    (aluSrc2),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .hiLoWrite  (hiLoWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .branch     (branch),
        .jump       (jump),
        .dataType   (dataType),
        .aluOp      (aluOp),
        .signExtend (signExtend),
        .ctrlValid  (ctrlValid)
    );

    initial Clk = 1'b0;
    always #50 Clk = ~Clk;

    task automatic sendInstr(logic [INSTR_W-1:0] word, logic valid);
        @(posedge Clk);
        instr      <= word;
        instrValid <= valid;
    endtask

    function automatic logic [31:0] buildWord(logic [5:0] op, logic rsLow, logic [4:0] rt,
                                              logic [4:0] sa, logic [5:0] fn);
        return {op, 4'h5, rsLow, rt, 5'd12, sa, fn};   // rd fixed at 12
    endfunction

    function automatic logic [31:0] withRandomLow(logic [5:0] op);
        logic [31:0] r;
        r = $urandom;
        return {op, r[25:0]};
    endfunction

    // Half from listed opcodes and half fully random
    function automatic logic [31:0] randomWord();
        logic [31:0] pick;
        int          idx;
        pick = $urandom;
        idx  = $urandom % 24;
        if (pick[0])
            return withRandomLow(knownOps[idx]);
        else
            return $urandom;
    endfunction

    task automatic reportMismatch(string name, logic [31:0] expV, logic [31:0] actV);
        $display("Mismatch %s expected %h got %h at cycle %0d", name, expV, actV, cycleCount);
        mismatchCount++;
    endtask

    // Expectation taken at the sampling edge and outputs checked half a cycle later
    initial begin : compare
        ctrlPkg::ctrl_t expCtrl;
        logic           expValid;
        forever begin
            @(posedge Clk);
            if (rst || !instrValid) begin
                expCtrl  = idleCtrl();
                expValid = 1'b0;
            end else begin
                expCtrl  = decodeRef(instr);
                expValid = 1'b1;
            end
            @(negedge Clk);
            if (ctrlValid !== expValid)
                reportMismatch("ctrlValid", 32'(expValid), 32'(ctrlValid));
            if (regDst !== expCtrl.regDst)
                reportMismatch("regDst", 32'(expCtrl.regDst), 32'(regDst));
            if (aluSrc !== expCtrl.aluSrc)
                reportMismatch("aluSrc", 32'(expCtrl.aluSrc), 32'(aluSrc));
            if (aluSrc2 !== expCtrl.aluSrc2)
                reportMismatch("aluSrc2", 32'(expCtrl.aluSrc2), 32'(aluSrc2));
            if (memToReg !== expCtrl.memToReg)
                reportMismatch("memToReg", 32'(expCtrl.memToReg), 32'(memToReg));
            if (regWrite !== expCtrl.regWrite)
                reportMismatch("regWrite", 32'(expCtrl.regWrite), 32'(regWrite));
            if (hiLoWrite !== expCtrl.hiLoWrite)
                reportMismatch("hiLoWrite", 32'(expCtrl.hiLoWrite), 32'(hiLoWrite));
            if (memRead !== expCtrl.memRead)
                reportMismatch("memRead", 32'(expCtrl.memRead), 32'(memRead));
            if (memWrite !== expCtrl.memWrite)
                reportMismatch("memWrite", 32'(expCtrl.memWrite), 32'(memWrite));
            if (branch !== expCtrl.branch)
                reportMismatch("branch", 32'(expCtrl.branch), 32'(branch));
            if (jump !== expCtrl.jump)
                reportMismatch("jump", 32'(expCtrl.jump), 32'(jump));
            if (dataType !== expCtrl.dataType)
                reportMismatch("dataType", 32'(expCtrl.dataType), 32'(dataType));
            if (aluOp !== expCtrl.aluOp)
                reportMismatch("aluOp", 32'(expCtrl.aluOp), 32'(aluOp));
            if (signExtend !== expCtrl.signExtend)
                reportMismatch("signExtend", 32'(expCtrl.signExtend), 32'(signExtend));
        end
    end

    always @(posedge Clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            otherCount++;
            $display("Timeout: stimulus still running after %0d cycles", cycleCount);
            $display("Errors: %0d mismatches, %0d other", mismatchCount, otherCount);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int          i;
        logic [31:0] v;
        void'($urandom(84));
        rst        = 1'b1;
        // A valid lw held through reset must still give a bubble
        instr      = buildWord(6'h23, 1'b0, 5'd3, 5'd0, 6'h00);
        instrValid = 1'b1;
        knownOps   = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
                       6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F,
                       6'h1C, 6'h1F, 6'h20, 6'h21, 6'h23, 6'h28, 6'h29, 6'h2B};

        repeat (4) @(posedge Clk);
        rst        <= 1'b0;
        instrValid <= 1'b0;
        repeat (2) sendInstr('0, 1'b0);   // Idle right after reset

        // SPECIAL table with both bit 21 and shamt variants
        for (i = 0; i < 64; i++) begin
            sendInstr(buildWord(6'h00, 1'b0, 5'd3, 5'd0, 6'(i)), 1'b1);
            sendInstr(buildWord(6'h00, 1'b1, 5'd3, 5'd1, 6'(i)), 1'b1);
        end
        sendInstr(buildWord(6'h00, 1'b0, 5'd3, 5'd2, 6'h06), 1'b1);

        // SPECIAL2, REGIMM and SPECIAL3 sub-fields
        for (i = 0; i < 64; i++)
            sendInstr(buildWord(6'h1C, 1'b0, 5'd3, 5'd0, 6'(i)), 1'b1);
        for (i = 0; i < 32; i++)
            sendInstr(buildWord(6'h01, 1'b0, 5'(i), 5'd0, 6'h00), 1'b1);
        for (i = 0; i < 32; i++)
            sendInstr(buildWord(6'h1F, 1'b0, 5'd3, 5'(i), 6'h20), 1'b1);

        // Every opcode once
        for (i = 0; i < 64; i++)
            sendInstr(withRandomLow(6'(i)), 1'b1);

        for (i = 0; i < 2000; i++)
            sendInstr(randomWord(), 1'b1);

        // Valid roughly three slots in four
        for (i = 0; i < 120; i++) begin
            v = $urandom;
            sendInstr(randomWord(), v[0] | v[1]);
        end

        repeat (3) sendInstr('0, 1'b0);
        @(negedge Clk);
        @(posedge Clk);

        $display("Errors: %0d mismatches, %0d other", mismatchCount, otherCount);
        if (mismatchCount + otherCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== controlUnit.f ====
+incdir+bench
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/funcDecIf.sv
verilog/funcDecoder.sv
verilog/mainDecoder.sv
verilog/controlUnit.sv
bench/controlUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module controlUnitTb -f controlUnit.f \
    && ./obj_dir/VcontrolUnitTb | tee /dev/stderr | grep -F "Regression passed" > /dev/null \
    && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }
